//--- source/reorder_cfg_pkg.sv
/*
 * Subsystem sizes for the rotating crossbar.
 * Channel counts, bank depth and the rotation offset type.
 */
`default_nettype none

package reorder_cfg_pkg;

  localparam int unsigned NB_IN_CHAN  = 3;   // Accelerator channels.
  localparam int unsigned NB_OUT_CHAN = 4;   // Memory banks.

  // Offset width, log2 of the bank count.
  localparam int unsigned ORDER_W = 2;

  localparam int unsigned BANK_WORDS = 64;   // Words per bank.

  // Rotation offset, wraps with the bank count.
  typedef logic [ORDER_W-1:0] order_t;

  typedef logic [NB_IN_CHAN-1:0]  in_vec_t;  // One bit per channel.
  typedef logic [NB_OUT_CHAN-1:0] out_vec_t; // One bit per bank.

endpackage

`default_nettype wire

//--- source/reorder_order_ctrl.sv
/*
 * Rotation offset counter, advanced after every granted cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module reorder_order_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  reorder_cfg_pkg::in_vec_t in_gnt_i,
  output reorder_cfg_pkg::order_t  order_o
);

  logic                    any_gnt;              // Traffic flowed this cycle.
  reorder_cfg_pkg::order_t order_q;

  assign any_gnt = |in_gnt_i;

  // Offset moves only with real traffic, so bank use evens out.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      order_q <= '0;
    end else if (clear_i) begin
      order_q <= '0;                             // Back to identity mapping.
    end else if (any_gnt) begin
      order_q <= order_q + reorder_cfg_pkg::order_t'(1); // Wraps 3 to 0.
    end
  end

  assign order_o = order_q;

  // Idle cycles leave the mapping unchanged.
  a_order_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (!any_gnt && !clear_i) |=> $stable(order_o)
  ) else $error("order changed without a grant");

endmodule

`default_nettype wire

//--- source/tcdm_bank.sv
/*
 * Word-wide memory bank with stall-gated grant.
 * Byte-enable writes and a registered one-cycle response.
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       stall_i,    // Contention from other masters.
  input  logic                       req_i,
  input  logic                       wen_i,      // 1 read, 0 write.
  input  tcdm_proto_pkg::tcdm_addr_t add_i,
  input  tcdm_proto_pkg::tcdm_be_t   be_i,
  input  tcdm_proto_pkg::tcdm_data_t data_i,
  output logic                       gnt_o,
  output logic                       r_valid_o,
  output tcdm_proto_pkg::tcdm_data_t r_data_o
);

  tcdm_proto_pkg::tcdm_data_t mem [reorder_cfg_pkg::BANK_WORDS]; // Storage.
  tcdm_proto_pkg::tcdm_data_t r_data_q;

  assign gnt_o = req_i & ~stall_i;               // Same-cycle grant.

  // Write merge at the grant edge.
  always_ff @(posedge clk_i) begin : mem_wr
    if (gnt_o && !wen_i) begin
      for (int b = 0; b < tcdm_proto_pkg::BE_W; b++) begin
        if (be_i[b]) begin
          mem[add_i][b*tcdm_proto_pkg::BYTE_W +: tcdm_proto_pkg::BYTE_W] <=
            data_i[b*tcdm_proto_pkg::BYTE_W +: tcdm_proto_pkg::BYTE_W];
        end
      end
    end
  end

  // Read data register.
  always_ff @(posedge clk_i) begin : mem_rd
    if (gnt_o && wen_i) begin
      r_data_q <= mem[add_i];                    // Word before any write.
    end
  end

  // Every grant, read or write, gets one response.
  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      r_valid_o <= 1'b0;
    end else begin
      r_valid_o <= gnt_o;
    end
  end

  assign r_data_o = r_data_q;

  // A stalled cycle is neither granted nor answered next cycle.
  a_stall_no_resp : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    stall_i |-> !gnt_o ##1 !r_valid_o
  ) else $error("bank answered a stalled request");

endmodule

`default_nettype wire

//--- source/tcdm_proto_pkg.sv
/*
 * Memory protocol widths for the req/gnt bank interface.
 * Word address, data word and byte-enable vector types.
 */
`default_nettype none

package tcdm_proto_pkg;

  // Word address inside one bank, 64 words.
  localparam int unsigned ADDR_W = 6;

  localparam int unsigned DATA_W = 32;       // Bus data width.
  localparam int unsigned BE_W   = 4;        // One enable per byte lane.

  // Bits per byte lane, used by the bank write merge.
  localparam int unsigned BYTE_W = DATA_W / BE_W;

  typedef logic [ADDR_W-1:0] tcdm_addr_t;    // Word address.
  typedef logic [DATA_W-1:0] tcdm_data_t;    // Data word.
  typedef logic [BE_W-1:0]   tcdm_be_t;      // Byte enables.

endpackage

`default_nettype wire

//--- source/tcdm_reorder.sv
/*
 * Rotating crossbar from accelerator channels to bank ports.
 * Combinational request and grant paths, registered response routing.
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_reorder (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  input  logic                                                       clear_i,
  input  reorder_cfg_pkg::order_t                                    order_i,
  // Accelerator side.
  input  reorder_cfg_pkg::in_vec_t                                   in_req_i,
  input  reorder_cfg_pkg::in_vec_t                                   in_wen_i,
  input  tcdm_proto_pkg::tcdm_addr_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_add_i,
  input  tcdm_proto_pkg::tcdm_be_t   [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_be_i,
  input  tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_data_i,
  output reorder_cfg_pkg::in_vec_t                                   in_gnt_o,
  output reorder_cfg_pkg::in_vec_t                                   in_r_valid_o,
  output tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_r_data_o,
  // Bank side.
  output reorder_cfg_pkg::out_vec_t                                  out_req_o,
  output reorder_cfg_pkg::out_vec_t                                  out_wen_o,
  output tcdm_proto_pkg::tcdm_addr_t [reorder_cfg_pkg::NB_OUT_CHAN-1:0] out_add_o,
  output tcdm_proto_pkg::tcdm_be_t   [reorder_cfg_pkg::NB_OUT_CHAN-1:0] out_be_o,
  output tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_OUT_CHAN-1:0] out_data_o,
  input  reorder_cfg_pkg::out_vec_t                                  out_gnt_i,
  input  reorder_cfg_pkg::out_vec_t                                  out_r_valid_i,
  input  tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_OUT_CHAN-1:0] out_r_data_i
);

  reorder_cfg_pkg::order_t [reorder_cfg_pkg::NB_OUT_CHAN-1:0] win_idx;    // Input per bank.
  reorder_cfg_pkg::order_t [reorder_cfg_pkg::NB_IN_CHAN-1:0]  bank_sel;   // Bank per input.
  reorder_cfg_pkg::order_t [reorder_cfg_pkg::NB_IN_CHAN-1:0]  bank_sel_q; // Bank at grant.
  reorder_cfg_pkg::out_vec_t                                  out_req_q;  // Bank was requested.

  // Bank side muxes.
  for (genvar j = 0; j < reorder_cfg_pkg::NB_OUT_CHAN; j++) begin : gen_out
    // Bank j takes input (order + j) mod 4.
    assign win_idx[j] = order_i + reorder_cfg_pkg::order_t'(j);

    always_comb begin : mux_req
      out_req_o[j]  = 1'b0;                      // Idle request by default.
      out_wen_o[j]  = 1'b0;
      out_add_o[j]  = '0;
      out_be_o[j]   = '0;
      out_data_o[j] = '0;
      for (int i = 0; i < reorder_cfg_pkg::NB_IN_CHAN; i++) begin
        if (win_idx[j] == reorder_cfg_pkg::order_t'(i)) begin
          out_req_o[j]  = in_req_i[i];
          out_wen_o[j]  = in_wen_i[i];
          out_add_o[j]  = in_add_i[i];
          out_be_o[j]   = in_be_i[i];
          out_data_o[j] = in_data_i[i];
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : req_reg
      if (!rst_ni) begin
        out_req_q[j] <= 1'b0;
      end else if (clear_i) begin
        out_req_q[j] <= 1'b0;                    // Drop any pending response.
      end else begin
        out_req_q[j] <= out_req_o[j];
      end
    end
  end

  // Input side routing.
  for (genvar i = 0; i < reorder_cfg_pkg::NB_IN_CHAN; i++) begin : gen_in
    // Input i goes to bank (i + 4 - order) mod 4.
    assign bank_sel[i] = reorder_cfg_pkg::order_t'(i) - order_i;
    assign in_gnt_o[i] = out_gnt_i[bank_sel[i]];

    always_ff @(posedge clk_i or negedge rst_ni) begin : sel_reg
      if (!rst_ni) begin
        bank_sel_q[i] <= '0;
      end else if (clear_i) begin
        bank_sel_q[i] <= '0;
      end else begin
        bank_sel_q[i] <= bank_sel[i];            // Remember mapping for the response.
      end
    end

    // Response comes from the bank that held this input last cycle.
    assign in_r_data_o[i]  = out_r_data_i[bank_sel_q[i]];
    assign in_r_valid_o[i] = out_r_valid_i[bank_sel_q[i]] & out_req_q[bank_sel_q[i]];

    // A response only follows a grant on the same channel.
    a_rvalid_after_gnt : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      in_r_valid_o[i] |-> $past(in_gnt_o[i])
    ) else $error("r_valid on channel %0d without a grant", i);
  end

endmodule

`default_nettype wire

//--- source/tcdm_reorder_subsys.sv
/*
 * Top level of the reorder subsystem.
 * Order counter, rotating crossbar and four memory banks.
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_reorder_subsys (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  input  logic                                                       clear_i,
  input  reorder_cfg_pkg::out_vec_t                                  bank_stall_i,
  input  reorder_cfg_pkg::in_vec_t                                   in_req_i,
  input  reorder_cfg_pkg::in_vec_t                                   in_wen_i,
  input  tcdm_proto_pkg::tcdm_addr_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_add_i,
  input  tcdm_proto_pkg::tcdm_be_t   [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_be_i,
  input  tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_data_i,
  output reorder_cfg_pkg::in_vec_t                                   in_gnt_o,
  output reorder_cfg_pkg::in_vec_t                                   in_r_valid_o,
  output tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_r_data_o
);

  reorder_cfg_pkg::order_t order;                // Current rotation offset.

  // Crossbar to bank wires.
  reorder_cfg_pkg::out_vec_t                                  bank_req;
  reorder_cfg_pkg::out_vec_t                                  bank_wen;
  tcdm_proto_pkg::tcdm_addr_t [reorder_cfg_pkg::NB_OUT_CHAN-1:0] bank_add;
  tcdm_proto_pkg::tcdm_be_t   [reorder_cfg_pkg::NB_OUT_CHAN-1:0] bank_be;
  tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_OUT_CHAN-1:0] bank_data;
  reorder_cfg_pkg::out_vec_t                                  bank_gnt;
  reorder_cfg_pkg::out_vec_t                                  bank_r_valid;
  tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_OUT_CHAN-1:0] bank_r_data;

  reorder_order_ctrl u_order (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .in_gnt_i (in_gnt_o),                        // Advances on any grant.
    .order_o  (order)
  );

  tcdm_reorder u_reorder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .order_i       (order),
    .in_req_i      (in_req_i),
    .in_wen_i      (in_wen_i),
    .in_add_i      (in_add_i),
    .in_be_i       (in_be_i),
    .in_data_i     (in_data_i),
    .in_gnt_o      (in_gnt_o),
    .in_r_valid_o  (in_r_valid_o),
    .in_r_data_o   (in_r_data_o),
    .out_req_o     (bank_req),
    .out_wen_o     (bank_wen),
    .out_add_o     (bank_add),
    .out_be_o      (bank_be),
    .out_data_o    (bank_data),
    .out_gnt_i     (bank_gnt),
    .out_r_valid_i (bank_r_valid),
    .out_r_data_i  (bank_r_data)
  );

  // One bank per crossbar output.
  for (genvar j = 0; j < reorder_cfg_pkg::NB_OUT_CHAN; j++) begin : gen_bank
    tcdm_bank u_bank (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .stall_i   (bank_stall_i[j]),
      .req_i     (bank_req[j]),
      .wen_i     (bank_wen[j]),
      .add_i     (bank_add[j]),
      .be_i      (bank_be[j]),
      .data_i    (bank_data[j]),
      .gnt_o     (bank_gnt[j]),
      .r_valid_o (bank_r_valid[j]),
      .r_data_o  (bank_r_data[j])
    );
  end

endmodule

`default_nettype wire

//--- tcdm_reorder_subsys.f
source/tcdm_proto_pkg.sv
source/reorder_cfg_pkg.sv
source/reorder_order_ctrl.sv
source/tcdm_bank.sv
source/tcdm_reorder.sv
source/tcdm_reorder_subsys.sv
testbench/tb_tcdm_checker.sv
testbench/tb_tcdm_reorder_subsys.sv

//--- testbench/tb_tcdm_checker.sv
/*
 * Testbench checker for the reorder subsystem.
 * Models the rotation offset and the four banks, compares grants and responses.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_checker (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  input  logic                                                       clear_i,
  input  reorder_cfg_pkg::out_vec_t                                  bank_stall_i,
  input  reorder_cfg_pkg::in_vec_t                                   in_req_i,
  input  reorder_cfg_pkg::in_vec_t                                   in_wen_i,
  input  tcdm_proto_pkg::tcdm_addr_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_add_i,
  input  tcdm_proto_pkg::tcdm_be_t   [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_be_i,
  input  tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_data_i,
  input  reorder_cfg_pkg::in_vec_t                                   in_gnt_o,
  input  reorder_cfg_pkg::in_vec_t                                   in_r_valid_o,
  input  tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_r_data_o
);

  int unsigned err_cnt;                          // Mismatches seen.
  int unsigned chk_cnt;                          // Compares made.

  reorder_cfg_pkg::order_t    order_m;           // Model rotation offset.
  tcdm_proto_pkg::tcdm_data_t bank_m [reorder_cfg_pkg::NB_OUT_CHAN]
                                     [reorder_cfg_pkg::BANK_WORDS]; // Model banks, start as X.
  reorder_cfg_pkg::in_vec_t   pend_gnt;          // Granted last cycle.
  reorder_cfg_pkg::in_vec_t   pend_rd;           // Last cycle's requests were reads.
  tcdm_proto_pkg::tcdm_data_t pend_data [reorder_cfg_pkg::NB_IN_CHAN]; // Expected read words.

  initial begin
    err_cnt  = 0;
    chk_cnt  = 0;
    order_m  = '0;
    pend_gnt = '0;
    pend_rd  = '0;
  end

  // Bank reached by channel ch under offset ord.
  function automatic int bank_of(input int ch, input int ord);
    return (ch + 4 - ord) % 4;
  endfunction

  // Byte lanes under be take the new word, the others keep the old one.
  function automatic tcdm_proto_pkg::tcdm_data_t merge_bytes(
    input tcdm_proto_pkg::tcdm_data_t old_w,
    input tcdm_proto_pkg::tcdm_data_t new_w,
    input tcdm_proto_pkg::tcdm_be_t   be
  );
    tcdm_proto_pkg::tcdm_data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic compare_hex(input string name, input int ch,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    chk_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("** Error: %s[%0d] expected %h, got %h at %0t", name, ch, exp_v, act_v, $time);
    end
  endtask

  // Values are sampled before the edge updates any register.
  always @(posedge clk_i) begin : check_cycle
    reorder_cfg_pkg::in_vec_t exp_gnt;
    int bk;
    if (!rst_ni) begin
      for (int i = 0; i < 3; i++) compare_hex("in_r_valid_o", i, 32'(0), 32'(in_r_valid_o[i]));
      order_m  = '0;
      pend_gnt = '0;
      pend_rd  = '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        bk = bank_of(i, order_m);
        exp_gnt[i] = in_req_i[i] & ~bank_stall_i[bk]; // Stalled bank holds the request.
        compare_hex("in_gnt_o", i, 32'(exp_gnt[i]), 32'(in_gnt_o[i]));
        compare_hex("in_r_valid_o", i, 32'(pend_gnt[i]), 32'(in_r_valid_o[i]));
        if (pend_gnt[i] && pend_rd[i]) begin
          compare_hex("in_r_data_o", i, pend_data[i], in_r_data_o[i]);
        end
      end
      for (int i = 0; i < 3; i++) begin
        bk = bank_of(i, order_m);
        if (exp_gnt[i] && in_wen_i[i]) begin
          pend_data[i] = bank_m[bk][in_add_i[i]];  // Read sees the word before this edge.
        end else if (exp_gnt[i]) begin
          bank_m[bk][in_add_i[i]] = merge_bytes(bank_m[bk][in_add_i[i]], in_data_i[i],
                                                in_be_i[i]);
        end
      end
      pend_gnt = clear_i ? '0 : exp_gnt;         // Clear drops pending responses.
      pend_rd  = in_wen_i;
      if (clear_i) order_m = '0;
      else if (|exp_gnt) order_m = order_m + 2'd1; // Wraps 3 to 0.
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_tcdm_reorder_subsys.sv
/*
 * Testbench top for the reorder subsystem.
 * Clock, reset, stimulus reader, request driver, DUT, checker and watchdog.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_reorder_subsys;

  localparam string STIM_FILE      = "testbench/tcdm_stimulus.txt";
  localparam int    MAX_RECS       = 64;
  localparam int    CYCLES_PER_REC = 8;
  localparam int    TIMEOUT_MARGIN = 50;

  logic                                                         clk;
  logic                                                         rst_n;
  logic                                                         clear;
  reorder_cfg_pkg::out_vec_t                                    bank_stall;
  reorder_cfg_pkg::in_vec_t                                     in_req;
  reorder_cfg_pkg::in_vec_t                                     in_wen;
  tcdm_proto_pkg::tcdm_addr_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_add;
  tcdm_proto_pkg::tcdm_be_t   [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_be;
  tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_data;
  reorder_cfg_pkg::in_vec_t                                     in_gnt;
  reorder_cfg_pkg::in_vec_t                                     in_r_valid;
  tcdm_proto_pkg::tcdm_data_t [reorder_cfg_pkg::NB_IN_CHAN-1:0] in_r_data;

  // Stimulus records as read from the file.
  logic                       rec_clr   [MAX_RECS];
  reorder_cfg_pkg::out_vec_t  rec_stall [MAX_RECS];
  reorder_cfg_pkg::in_vec_t   rec_req   [MAX_RECS];
  reorder_cfg_pkg::in_vec_t   rec_wen   [MAX_RECS];
  tcdm_proto_pkg::tcdm_addr_t rec_add   [MAX_RECS][3];
  tcdm_proto_pkg::tcdm_be_t   rec_be    [MAX_RECS][3];
  tcdm_proto_pkg::tcdm_data_t rec_data  [MAX_RECS][3];

  int unsigned n_recs    = 0;
  int unsigned tb_err    = 0;                    // Driver side failures.
  int unsigned cycle_cnt = 0;
  int unsigned cycle_lim = 0;                    // Set once the records are known.

  tcdm_reorder_subsys u_dut (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (clear), .bank_stall_i (bank_stall),
    .in_req_i (in_req), .in_wen_i (in_wen), .in_add_i (in_add), .in_be_i (in_be),
    .in_data_i (in_data), .in_gnt_o (in_gnt), .in_r_valid_o (in_r_valid),
    .in_r_data_o (in_r_data)
  );

  tb_tcdm_checker u_chk (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (clear), .bank_stall_i (bank_stall),
    .in_req_i (in_req), .in_wen_i (in_wen), .in_add_i (in_add), .in_be_i (in_be),
    .in_data_i (in_data), .in_gnt_o (in_gnt), .in_r_valid_o (in_r_valid),
    .in_r_data_o (in_r_data)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #4 clk = ~clk;                       // 8 ns period.
  end

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_clr, f_stall;
    logic [31:0] f_req [3], f_wen [3], f_add [3], f_be [3], f_data [3];
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      tb_err++;
      $display("Could not open the stimulus file %s", STIM_FILE);
      return;
    end
    while (!$feof(fd) && n_recs < MAX_RECS) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() == 0 || line[0] == "#") continue; // Column notes.
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f_clr, f_stall,
                  f_req[0], f_wen[0], f_add[0], f_be[0], f_data[0],
                  f_req[1], f_wen[1], f_add[1], f_be[1], f_data[1],
                  f_req[2], f_wen[2], f_add[2], f_be[2], f_data[2]);
      if (n == 17) begin
        rec_clr[n_recs]   = f_clr[0];
        rec_stall[n_recs] = f_stall[3:0];
        for (int c = 0; c < 3; c++) begin
          rec_req[n_recs][c]  = f_req[c][0];
          rec_wen[n_recs][c]  = f_wen[c][0];
          rec_add[n_recs][c]  = f_add[c][5:0];
          rec_be[n_recs][c]   = f_be[c][3:0];
          rec_data[n_recs][c] = f_data[c];
        end
        n_recs++;
      end else if (n > 0) begin
        tb_err++;
        $display("Stimulus line %0d has %0d fields instead of 17", n_recs + 1, n);
      end
    end
    $fclose(fd);
  endtask

  // Hold the record until every request is granted, then drop each one at its grant.
  task automatic apply_record(input int r);
    reorder_cfg_pkg::in_vec_t pending;
    pending = rec_req[r];
    @(negedge clk);
    clear      = rec_clr[r];
    bank_stall = rec_stall[r];                   // Stall mask for the first cycle only.
    in_req     = pending;
    in_wen     = rec_wen[r];
    for (int c = 0; c < 3; c++) begin
      in_add[c]  = rec_add[r][c];
      in_be[c]   = rec_be[r][c];
      in_data[c] = rec_data[r][c];
    end
    @(posedge clk);
    pending = pending & ~in_gnt;
    while (pending != '0) begin
      @(negedge clk);
      clear      = 1'b0;
      bank_stall = '0;
      in_req     = pending;
      @(posedge clk);
      pending = pending & ~in_gnt;
    end
  endtask

  initial begin : watchdog
    wait (cycle_lim != 0);
    while (cycle_cnt < cycle_lim) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the stimulus did not complete within %0d cycles", cycle_lim);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : run
    rst_n      = 1'b0;
    clear      = 1'b0;
    bank_stall = '0;
    in_req     = '0;
    in_wen     = '0;
    in_add     = '0;
    in_be      = '0;
    in_data    = '0;
    load_stimulus();
    cycle_lim = n_recs * CYCLES_PER_REC + TIMEOUT_MARGIN;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int r = 0; r < n_recs; r++) apply_record(r);
    @(negedge clk);
    in_req = '0;
    clear  = 1'b0;
    repeat (3) @(posedge clk);                   // Last responses get checked.
    @(negedge clk);
    $display("Records: %0d, checks: %0d, checker errors: %0d, driver errors: %0d",
             n_recs, u_chk.chk_cnt, u_chk.err_cnt, tb_err);
    if (u_chk.err_cnt == 0 && tb_err == 0 && n_recs != 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tcdm_stimulus.txt
# clr stall | ch0: req wen(1 rd) add be data | ch1: same | ch2: same  (all hex)
# Stall mask applies in the first cycle of a record only.
0 0  1 0 00 f 11111111  1 0 00 f 22222222  1 0 00 f 33333333
0 0  1 0 00 f 44444444  1 0 01 f 55555555  1 0 01 f 66666666
0 0  1 0 01 f 77777777  1 0 01 f 88888888  1 0 02 f 99999999
0 0  1 1 00 0 00000000  1 1 01 0 00000000  1 0 00 5 a5a5a5a5
0 0  1 0 01 8 de000000  1 1 00 0 00000000  1 1 00 0 00000000
0 0  1 1 00 0 00000000  1 1 01 0 00000000  0 0 00 0 00000000
0 8  1 1 00 0 00000000  1 0 00 f cafef00d  1 1 01 0 00000000
0 f  1 1 02 0 00000000  1 1 01 0 00000000  1 1 00 0 00000000
1 0  0 0 00 0 00000000  0 0 00 0 00000000  0 0 00 0 00000000
0 0  1 1 00 0 00000000  1 1 00 0 00000000  1 1 00 0 00000000
0 9  1 1 01 0 00000000  1 1 00 0 00000000  1 1 01 0 00000000
0 0  0 0 00 0 00000000  0 0 00 0 00000000  0 0 00 0 00000000
0 0  1 0 3f f 0badc0de  1 1 00 0 00000000  1 1 01 0 00000000
0 0  0 0 00 0 00000000  1 1 3f 0 00000000  0 0 00 0 00000000
1 0  0 0 00 0 00000000  0 0 00 0 00000000  0 0 00 0 00000000
